/* nibble_pkg.sv */
package nibble_pkg;

    localparam int NIBBLE_W   = 4;   // bits handled per serial step.
    localparam int NUM_STEPS  = 8;   // nibbles in one 32-bit word.
    localparam int NUM_REGS   = 16;  // RV32E-sized register file.
    localparam int REG_ADDR_W = 4;

    // major opcodes of the supported RV32I instructions.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    typedef logic [NIBBLE_W-1:0]           nibble_t;
    typedef logic [NIBBLE_W*NUM_STEPS-1:0] word_t;
    typedef logic [31:0]                   instr_t;
    typedef logic [REG_ADDR_W-1:0]         reg_addr_t;
    typedef logic [$clog2(NUM_STEPS)-1:0]  step_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B  // used by LUI, the immediate goes straight through.
    } alu_op_t;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_EXEC,
        DEC_WAIT
    } dec_state_t;

endpackage

/* nibble_alu.sv */
`timescale 1ns/100ps

module nibble_alu import nibble_pkg::*; (
    input  alu_op_t op,
    input  nibble_t a,
    input  nibble_t b,
    input  logic    carry_in,
    output nibble_t y,
    output logic    carry_out
);

    nibble_t b_eff;
    logic [NIBBLE_W:0] sum;

    // subtraction is a + ~b with the carry forced to one on the first step.
    assign b_eff = (op == ALU_SUB) ? ~b : b;
    assign sum = {1'b0, a} + {1'b0, b_eff} + {{NIBBLE_W{1'b0}}, carry_in};

    always_comb begin
        y = sum[NIBBLE_W-1:0];
        carry_out = sum[NIBBLE_W];
        case (op)
            ALU_ADD, ALU_SUB: begin
                y = sum[NIBBLE_W-1:0];
                carry_out = sum[NIBBLE_W];  // ripples into the next nibble.
            end
            ALU_AND: begin
                y = a & b;
                carry_out = 1'b0;
            end
            ALU_OR: begin
                y = a | b;
                carry_out = 1'b0;
            end
            ALU_XOR: begin
                y = a ^ b;
                carry_out = 1'b0;
            end
            default: begin
                y = b;  // pass b for LUI.
                carry_out = 1'b0;
            end
        endcase
    end

endmodule

/* nibble_regfile.sv */
`timescale 1ns/100ps

module nibble_regfile import nibble_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  step_t     step,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  logic      wr_en,
    input  nibble_t   wr_nib,
    output nibble_t   rs1_nib,
    output nibble_t   rs2_nib
);

    word_t regs [NUM_REGS];

    // a register is accessed one slice at a time, lowest nibble at step 0.
    assign rs1_nib = regs[rs1][step*NIBBLE_W +: NIBBLE_W];
    assign rs2_nib = regs[rs2][step*NIBBLE_W +: NIBBLE_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (rd != '0)) begin  // x0 is never written.
            regs[rd][step*NIBBLE_W +: NIBBLE_W] <= wr_nib;
        end
    end

endmodule

/* instr_decoder.sv */
`timescale 1ns/100ps

module instr_decoder import nibble_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  instr_t     instr,
    input  word_t      instr_pc,
    input  logic       in_valid,
    output logic       in_ready,
    input  logic       result_pending,
    output logic       exec,
    output logic       last_step,
    output step_t      step,
    output reg_addr_t  rs1,
    output reg_addr_t  rs2,
    output reg_addr_t  rd,
    output alu_op_t    alu_op,
    output logic       use_pc,
    output logic       use_rs2,
    output logic       wr_allow,
    output logic       illegal,
    output nibble_t    imm_nib,
    output nibble_t    pc_nib
);

    dec_state_t state;
    instr_t instr_q;
    word_t pc_q;
    word_t imm_word;
    logic accept;
    logic use_u;      // upper immediate instead of the I immediate.
    logic reads_rs1;
    logic bad_code;
    logic bad_reg;

    assign in_ready = (state != DEC_EXEC) && !result_pending;
    assign accept = in_valid && in_ready;
    assign exec = (state == DEC_EXEC);
    assign last_step = exec && (step == step_t'(NUM_STEPS - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= DEC_IDLE;
            step <= '0;
        end else begin
            case (state)
                DEC_IDLE: begin
                    if (accept) begin
                        state <= DEC_EXEC;
                    end
                end
                DEC_EXEC: begin
                    step <= step + 1'b1;  // wraps back to zero after step 7.
                    if (last_step) begin
                        state <= DEC_WAIT;
                    end
                end
                default: begin
                    if (accept) begin
                        state <= DEC_EXEC;  // result just left, start the next one.
                    end else if (!result_pending) begin
                        state <= DEC_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= instr;
            pc_q <= instr_pc;
        end
    end

    always_comb begin
        alu_op = ALU_ADD;
        use_pc = 1'b0;
        use_rs2 = 1'b0;
        use_u = 1'b0;
        reads_rs1 = 1'b1;
        bad_code = 1'b0;
        case (instr_q[6:0])
            OPC_OP: begin
                use_rs2 = 1'b1;
                if (instr_q[31:25] == 7'b0100000 && instr_q[14:12] == 3'b000) begin
                    alu_op = ALU_SUB;
                end else if (instr_q[31:25] != 7'b0000000) begin
                    bad_code = 1'b1;
                end else begin
                    case (instr_q[14:12])
                        3'b000:  alu_op = ALU_ADD;
                        3'b100:  alu_op = ALU_XOR;
                        3'b110:  alu_op = ALU_OR;
                        3'b111:  alu_op = ALU_AND;
                        default: bad_code = 1'b1;
                    endcase
                end
            end
            OPC_OP_IMM: begin
                case (instr_q[14:12])
                    3'b000:  alu_op = ALU_ADD;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: bad_code = 1'b1;  // shifts and compares are not built.
                endcase
            end
            OPC_LUI: begin
                alu_op = ALU_PASS_B;
                use_u = 1'b1;
                reads_rs1 = 1'b0;
            end
            OPC_AUIPC: begin
                use_pc = 1'b1;
                use_u = 1'b1;
                reads_rs1 = 1'b0;
            end
            default: bad_code = 1'b1;
        endcase
    end

    // x16 to x31 do not exist in the 16-entry register file.
    assign bad_reg = instr_q[11] || (reads_rs1 && instr_q[19]) || (use_rs2 && instr_q[24]);
    assign illegal = bad_code || bad_reg;
    assign wr_allow = !illegal;

    assign rd = instr_q[10:7];
    assign rs1 = instr_q[18:15];
    assign rs2 = instr_q[23:20];

    assign imm_word = use_u ? {instr_q[31:12], 12'b0} : {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_nib = imm_word[step*NIBBLE_W +: NIBBLE_W];
    assign pc_nib = pc_q[step*NIBBLE_W +: NIBBLE_W];

endmodule

/* nibble_core.sv */
`timescale 1ns/100ps

module nibble_core import nibble_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    exec,
    input  step_t   step,
    input  alu_op_t alu_op,
    input  logic    use_pc,
    input  logic    use_rs2,
    input  logic    wr_allow,
    input  nibble_t imm_nib,
    input  nibble_t pc_nib,
    input  nibble_t rs1_nib,
    input  nibble_t rs2_nib,
    output logic    rd_wr_en,
    output nibble_t rd_nib
);

    nibble_t alu_a;
    nibble_t alu_b;
    nibble_t alu_y;
    logic carry_q;
    logic carry_in;
    logic carry_out;

    assign alu_a = use_pc ? pc_nib : rs1_nib;    // AUIPC adds to the pc.
    assign alu_b = use_rs2 ? rs2_nib : imm_nib;

    // the first nibble starts a fresh carry chain.
    assign carry_in = (step == '0) ? (alu_op == ALU_SUB) : carry_q;

    nibble_alu alu (
        .op        (alu_op),
        .a         (alu_a),
        .b         (alu_b),
        .carry_in  (carry_in),
        .y         (alu_y),
        .carry_out (carry_out)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            carry_q <= 1'b0;
        end else if (exec) begin
            carry_q <= carry_out;  // carry into the next nibble.
        end
    end

    assign rd_wr_en = exec && wr_allow;
    assign rd_nib = wr_allow ? alu_y : '0;  // illegal instructions report zero.

endmodule

/* result_collector.sv */
`timescale 1ns/100ps

module result_collector import nibble_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      capture,
    input  logic      last_step,
    input  reg_addr_t rd_in,
    input  logic      illegal_in,
    input  nibble_t   nib,
    input  logic      result_ready,
    output logic      result_valid,
    output reg_addr_t result_rd,
    output word_t     result_data,
    output logic      result_illegal
);

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else if (capture && last_step) begin
            result_valid <= 1'b1;  // the last nibble lands on this edge.
        end else if (result_valid && result_ready) begin
            result_valid <= 1'b0;
        end
    end

    // nibbles enter at the top, so step 0 ends up in the low bits.
    always_ff @(posedge clk) begin
        if (capture) begin
            result_data <= {nib, result_data[$bits(word_t)-1:NIBBLE_W]};
        end
        if (capture && last_step) begin
            result_rd <= rd_in;
            result_illegal <= illegal_in;
        end
    end

endmodule

/* serial_cpu_top.sv */
`timescale 1ns/100ps

module serial_cpu_top import nibble_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  instr_t    instr,
    input  word_t     instr_pc,
    input  logic      in_valid,
    output logic      in_ready,
    output logic      result_valid,
    input  logic      result_ready,
    output reg_addr_t result_rd,
    output word_t     result_data,
    output logic      result_illegal
);

    logic exec;
    logic last_step;
    step_t step;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    alu_op_t alu_op;
    logic use_pc;
    logic use_rs2;
    logic wr_allow;
    logic illegal;
    nibble_t imm_nib;
    nibble_t pc_nib;
    nibble_t rs1_nib;
    nibble_t rs2_nib;
    logic rd_wr_en;
    nibble_t rd_nib;

    instr_decoder decoder (
        .clk            (clk),
        .reset          (reset),
        .instr          (instr),
        .instr_pc       (instr_pc),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .result_pending (result_valid),
        .exec           (exec),
        .last_step      (last_step),
        .step           (step),
        .rs1            (rs1),
        .rs2            (rs2),
        .rd             (rd),
        .alu_op         (alu_op),
        .use_pc         (use_pc),
        .use_rs2        (use_rs2),
        .wr_allow       (wr_allow),
        .illegal        (illegal),
        .imm_nib        (imm_nib),
        .pc_nib         (pc_nib)
    );

    nibble_core core (
        .clk      (clk),
        .reset    (reset),
        .exec     (exec),
        .step     (step),
        .alu_op   (alu_op),
        .use_pc   (use_pc),
        .use_rs2  (use_rs2),
        .wr_allow (wr_allow),
        .imm_nib  (imm_nib),
        .pc_nib   (pc_nib),
        .rs1_nib  (rs1_nib),
        .rs2_nib  (rs2_nib),
        .rd_wr_en (rd_wr_en),
        .rd_nib   (rd_nib)
    );

    nibble_regfile regfile (
        .clk     (clk),
        .reset   (reset),
        .step    (step),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .wr_en   (rd_wr_en),
        .wr_nib  (rd_nib),
        .rs1_nib (rs1_nib),
        .rs2_nib (rs2_nib)
    );

    // capture follows exec, so an illegal instruction still collects zeros.
    result_collector collector (
        .clk            (clk),
        .reset          (reset),
        .capture        (exec),
        .last_step      (last_step),
        .rd_in          (rd),
        .illegal_in     (illegal),
        .nib            (rd_nib),
        .result_ready   (result_ready),
        .result_valid   (result_valid),
        .result_rd      (result_rd),
        .result_data    (result_data),
        .result_illegal (result_illegal)
    );

endmodule

/* serial_cpu_chk.sv */
`timescale 1ns/100ps

module serial_cpu_chk import nibble_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      in_ready,
    input logic      result_valid,
    input logic      result_ready,
    input reg_addr_t result_rd,
    input word_t     result_data,
    input logic      result_illegal
);

    int fail_count = 0;  // read by the testbench at the end of the run.

    hold_under_stall: assert property (@(posedge clk) disable iff (reset)
        result_valid && !result_ready |=> result_valid && $stable(result_data)
            && $stable(result_rd) && $stable(result_illegal))
    else begin
        $error("result changed or dropped while result_ready was low");
        fail_count++;
    end

    // one instruction in flight, so nothing is taken while a result waits.
    no_accept_when_pending: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> !in_ready)
    else begin
        $error("in_ready was high while result_valid was high");
        fail_count++;
    end

    idle_after_reset: assert property (@(posedge clk)
        reset |=> !result_valid && in_ready)
    else begin
        $error("result_valid high or in_ready low right after reset");
        fail_count++;
    end

endmodule

/* serial_cpu_monitor.sv */
`timescale 1ns/100ps

module serial_cpu_monitor import nibble_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  logic      in_ready,
    input  logic      result_valid,
    input  logic      result_ready,
    input  reg_addr_t result_rd,
    input  word_t     result_data,
    input  logic      result_illegal,
    output int        error_count,
    output int        received
);

    // results still owed by the DUT, oldest first.
    string name_q[$];
    reg_addr_t rd_q[$];
    word_t data_q[$];
    logic illegal_q[$];

    task automatic expect_result(input string name, input reg_addr_t rd, input word_t data,
                                 input logic illegal);
        name_q.push_back(name);
        rd_q.push_back(rd);
        data_q.push_back(data);
        illegal_q.push_back(illegal);
    endtask

    initial begin
        error_count = 0;
        received = 0;
    end

    always @(posedge clk) begin
        string name;
        reg_addr_t rd;
        word_t data;
        logic illegal;
        if (!reset && in_valid && in_ready && result_valid) begin
            $display("an instruction was accepted while a result was still pending");
            error_count++;
        end
        if (!reset && result_valid && result_ready) begin
            received++;
            if (name_q.size() == 0) begin
                $display("a result arrived with no instruction outstanding");
                error_count++;
            end else begin
                name = name_q.pop_front();
                rd = rd_q.pop_front();
                data = data_q.pop_front();
                illegal = illegal_q.pop_front();
                if (result_data !== data) begin
                    $display("CHECK FAILED %s data: expected %h, actual %h",
                             name, data, result_data);
                    error_count++;
                end
                if (result_rd !== rd) begin
                    $display("CHECK FAILED %s rd: expected %0d, actual %0d", name, rd, result_rd);
                    error_count++;
                end
                if (result_illegal !== illegal) begin
                    $display("CHECK FAILED %s illegal: expected %b, actual %b",
                             name, illegal, result_illegal);
                    error_count++;
                end
            end
        end
    end

endmodule

/* tb_serial_cpu.sv */
`timescale 1ns/100ps

module tb_serial_cpu import nibble_pkg::*; ();

    localparam int TIMEOUT = 200;  // cycles allowed for any single wait.

    logic clk;
    logic reset;
    instr_t instr;
    word_t instr_pc;
    logic in_valid;
    logic in_ready;
    logic result_valid;
    logic result_ready;
    reg_addr_t result_rd;
    word_t result_data;
    logic result_illegal;
    int mon_errors;
    int results_seen;
    logic timed_out;
    logic [31:0] rng = 32'd9096;

    // stimulus table and the expected columns filled in by the register model.
    string names[$];
    instr_t words[$];
    word_t pcs[$];
    reg_addr_t exp_rd[$];
    word_t exp_data[$];
    logic exp_illegal[$];
    word_t model_regs [32];

    serial_cpu_top UUT (
        .clk            (clk),
        .reset          (reset),
        .instr          (instr),
        .instr_pc       (instr_pc),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .result_valid   (result_valid),
        .result_ready   (result_ready),
        .result_rd      (result_rd),
        .result_data    (result_data),
        .result_illegal (result_illegal)
    );

    serial_cpu_monitor monitor (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .result_valid   (result_valid),
        .result_ready   (result_ready),
        .result_rd      (result_rd),
        .result_data    (result_data),
        .result_illegal (result_illegal),
        .error_count    (mon_errors),
        .received       (results_seen)
    );

    bind serial_cpu_top serial_cpu_chk chk (
        .clk            (clk),
        .reset          (reset),
        .in_ready       (in_ready),
        .result_valid   (result_valid),
        .result_ready   (result_ready),
        .result_rd      (result_rd),
        .result_data    (result_data),
        .result_illegal (result_illegal)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    function automatic instr_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                     input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
    endfunction

    function automatic instr_t enc_i(input logic [11:0] imm, input int rs1,
                                     input logic [2:0] f3, input int rd);
        return {imm, 5'(rs1), f3, 5'(rd), OPC_OP_IMM};
    endfunction

    function automatic instr_t enc_u(input logic [19:0] imm, input int rd, input logic [6:0] opc);
        return {imm, 5'(rd), opc};
    endfunction

    task automatic add_entry(input string name, input instr_t w, input word_t pc);
        names.push_back(name);
        words.push_back(w);
        pcs.push_back(pc);
    endtask

    task automatic build_table();
        add_entry("addi_pos", enc_i(12'd5, 0, 3'b000, 1), 32'h0);
        add_entry("addi_neg_one", enc_i(12'hfff, 0, 3'b000, 2), 32'h0);
        add_entry("lui_upper", enc_u(20'h10000, 3, OPC_LUI), 32'h0);
        add_entry("addi_borrow", enc_i(12'hfff, 3, 3'b000, 3), 32'h0);
        add_entry("addi_one", enc_i(12'd1, 0, 3'b000, 4), 32'h0);
        add_entry("add_carry_chain", enc_r(7'h00, 4, 3, 3'b000, 5), 32'h0);
        add_entry("sub_zero_minus_one", enc_r(7'h20, 4, 0, 3'b000, 6), 32'h0);
        add_entry("sub_borrow_chain", enc_r(7'h20, 4, 5, 3'b000, 7), 32'h0);
        add_entry("add_all_ones", enc_r(7'h00, 2, 2, 3'b000, 8), 32'h0);
        add_entry("lui_pattern", enc_u(20'h12345, 9, OPC_LUI), 32'h0);
        add_entry("addi_pattern", enc_i(12'h678, 9, 3'b000, 9), 32'h0);
        add_entry("and_reg", enc_r(7'h00, 3, 9, 3'b111, 10), 32'h0);
        add_entry("or_reg", enc_r(7'h00, 4, 9, 3'b110, 11), 32'h0);
        add_entry("xor_reg", enc_r(7'h00, 2, 9, 3'b100, 12), 32'h0);
        add_entry("andi_signed", enc_i(12'hff0, 9, 3'b111, 13), 32'h0);
        add_entry("ori_low", enc_i(12'h00f, 13, 3'b110, 13), 32'h0);
        add_entry("xori_invert", enc_i(12'hfff, 9, 3'b100, 14), 32'h0);
        add_entry("auipc_add", enc_u(20'habcde, 15, OPC_AUIPC), 32'h0000_1234);
        add_entry("auipc_wrap", enc_u(20'hfffff, 15, OPC_AUIPC), 32'h0000_2000);
        add_entry("addi_to_x0", enc_i(12'd77, 0, 3'b000, 0), 32'h0);
        add_entry("read_x0", enc_r(7'h00, 0, 0, 3'b000, 13), 32'h0);
        add_entry("slli_illegal", enc_i(12'd3, 1, 3'b001, 1), 32'h0);
        add_entry("read_after_slli", enc_i(12'd0, 1, 3'b000, 1), 32'h0);
        add_entry("slt_illegal", enc_r(7'h00, 4, 1, 3'b010, 2), 32'h0);
        add_entry("load_illegal", 32'h0000_2103, 32'h0);  // lw x2, 0(x0).
        add_entry("read_after_load", enc_r(7'h00, 0, 2, 3'b000, 2), 32'h0);
        add_entry("sub_self", enc_r(7'h20, 9, 9, 3'b000, 11), 32'h0);
    endtask

    // RV32I reference for the supported subset, kept on a 32-entry register image.
    task automatic model_instr(input instr_t ins, input word_t pc, output reg_addr_t rd,
                               output word_t data, output logic bad);
        word_t a;
        word_t b;
        word_t imm_i;
        word_t imm_u;
        logic [2:0] f3;
        logic [6:0] f7;
        a = model_regs[ins[19:15]];
        b = model_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_u = {ins[31:12], 12'h000};
        f3 = ins[14:12];
        f7 = ins[31:25];
        rd = ins[10:7];
        bad = 1'b0;
        data = '0;
        case (ins[6:0])
            OPC_OP: begin
                case ({f7, f3})
                    {7'h00, 3'b000}: data = a + b;
                    {7'h20, 3'b000}: data = a - b;
                    {7'h00, 3'b111}: data = a & b;
                    {7'h00, 3'b110}: data = a | b;
                    {7'h00, 3'b100}: data = a ^ b;
                    default: bad = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                case (f3)
                    3'b000: data = a + imm_i;
                    3'b111: data = a & imm_i;
                    3'b110: data = a | imm_i;
                    3'b100: data = a ^ imm_i;
                    default: bad = 1'b1;
                endcase
            end
            OPC_LUI: data = imm_u;
            OPC_AUIPC: data = pc + imm_u;
            default: bad = 1'b1;
        endcase
        if (bad) begin
            data = '0;  // an illegal instruction reports zero.
        end else if (ins[11:7] != 5'd0) begin
            model_regs[ins[11:7]] = data;
        end
    endtask

    task automatic compute_expected();
        reg_addr_t r;
        word_t d;
        logic b;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < names.size(); i++) begin
            model_instr(words[i], pcs[i], r, d, b);
            exp_rd.push_back(r);
            exp_data.push_back(d);
            exp_illegal.push_back(b);
        end
    endtask

    // random back-pressure on the result port.
    always @(negedge clk) begin
        if (!reset) begin
            rng = xorshift(rng);
            result_ready <= (rng[1:0] != 2'b00);
        end
    end

    initial begin
        int wait_cycles;
        logic accepted;
        clk = 1'b0;
        reset = 1'b1;
        instr = '0;
        instr_pc = '0;
        in_valid = 1'b0;
        result_ready <= 1'b0;
        timed_out = 1'b0;
        build_table();
        compute_expected();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < names.size() && !timed_out; i++) begin
            @(negedge clk);
            instr = words[i];
            instr_pc = pcs[i];
            in_valid = 1'b1;
            monitor.expect_result(names[i], exp_rd[i], exp_data[i], exp_illegal[i]);
            accepted = 1'b0;
            wait_cycles = 0;
            while (!accepted && wait_cycles < TIMEOUT) begin
                @(posedge clk);
                accepted = in_ready;  // in_valid is high, so ready means accepted.
                wait_cycles++;
            end
            if (!accepted) begin
                $display("timeout: instruction %s was never accepted", names[i]);
                timed_out = 1'b1;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;

        wait_cycles = 0;
        while (!timed_out && results_seen != names.size()) begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles >= TIMEOUT) begin
                $display("timeout: only %0d results came back", results_seen);
                timed_out = 1'b1;
            end
        end
        repeat (2) @(posedge clk);

        $display("errors: %0d compare, %0d assertion; results %0d of %0d",
                 mon_errors, UUT.chk.fail_count, results_seen, names.size());
        if (timed_out || mon_errors != 0 || UUT.chk.fail_count != 0) begin
            $display("*** TEST FAILED ***");
        end else begin
            $display("*** TEST PASSED ***");
        end
        $finish;
    end

endmodule

/* verilog.f */
nibble_pkg.sv
nibble_alu.sv
nibble_regfile.sv
instr_decoder.sv
nibble_core.sv
result_collector.sv
serial_cpu_top.sv
serial_cpu_chk.sv
serial_cpu_monitor.sv
tb_serial_cpu.sv

/* run.sh */
#!/bin/sh
# builds the serial RV32I testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_serial_cpu \
    -f verilog.f -o sim_serial_cpu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_serial_cpu +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
